/* hdl/rob_defines.svh */
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// reorder buffer geometry
// depth must stay a power of two so the pointers wrap on their own
`define ROB_DEPTH 16
`define NICK_W    4

// processor widths
`define REG_W     5
`define DATA_W    32
`define ADDR_W    32

`endif

/* hdl/cpu_types_pkg.sv */
`include "rob_defines.svh"

package cpu_types_pkg;

    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`REG_W-1:0]  regnm_t;

    // instruction classes seen by the reorder buffer
    typedef enum logic [3:0] {
        OP_ALU    = 4'd0,
        OP_LOAD   = 4'd1,
        OP_SB     = 4'd2,
        OP_SH     = 4'd3,
        OP_SW     = 4'd4,
        OP_BRANCH = 4'd5,
        OP_JAL    = 4'd6
    } opcode_t;

endpackage

/* hdl/rob_pkg.sv */
`include "rob_defines.svh"

package rob_pkg;

    // entry tag handed out at rename
    typedef logic [`NICK_W-1:0] nick_t;

    // one extra bit so a full buffer is distinct from an empty one
    typedef logic [`NICK_W:0] rob_cnt_t;

    typedef enum logic {
        COMMIT_RUN   = 1'b0,
        COMMIT_FLUSH = 1'b1
    } commit_state_t;

endpackage

/* hdl/rob_head_if.sv */
`timescale 1ns/1ps

interface rob_head_if;
    import cpu_types_pkg::*;
    import rob_pkg::*;

    // head entry, table to commit
    logic   head_valid;
    logic   head_done;
    logic   head_store;
    logic   head_mispred;
    regnm_t head_regnm;
    data_t  head_data;
    addr_t  head_jpc;
    nick_t  head_nick;

    // requests back to the table
    logic   retire;
    logic   flush_all;

    modport tbl (
        output head_valid, head_done, head_store, head_mispred,
        output head_regnm, head_data, head_jpc, head_nick,
        input  retire, flush_all
    );

    modport commit (
        input  head_valid, head_done, head_store, head_mispred,
        input  head_regnm, head_data, head_jpc, head_nick,
        output retire, flush_all
    );

endinterface

/* hdl/rob_entry_table.sv */
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_entry_table (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   alloc_valid,
    output logic                   alloc_ready,
    output rob_pkg::nick_t         alloc_nick,
    input  logic                   dp_valid,
    input  rob_pkg::nick_t         dp_nick,
    input  cpu_types_pkg::opcode_t dp_op,
    input  cpu_types_pkg::regnm_t  dp_regnm,
    input  logic                   dp_pd,
    input  logic                   ex_valid,
    input  rob_pkg::nick_t         ex_nick,
    input  cpu_types_pkg::data_t   ex_data,
    input  logic                   ex_ac,
    input  cpu_types_pkg::addr_t   ex_jpc,
    input  logic                   ld_valid,
    input  rob_pkg::nick_t         ld_nick,
    input  cpu_types_pkg::data_t   ld_data,
    rob_head_if.tbl                head
);
    import cpu_types_pkg::*;
    import rob_pkg::*;

    localparam int DEPTH = `ROB_DEPTH;

    // per-entry control bits
    logic [DEPTH-1:0] occupied;
    logic [DEPTH-1:0] dispatched;
    logic [DEPTH-1:0] done;
    logic [DEPTH-1:0] store;

    // per-entry payload
    logic [DEPTH-1:0] pd;
    logic [DEPTH-1:0] ac;
    regnm_t           regnm [DEPTH];
    data_t            data  [DEPTH];
    addr_t            jpc   [DEPTH];

    nick_t    head_ptr;
    nick_t    tail_ptr;
    rob_cnt_t count;

    logic alloc_fire;
    logic dp_store;
    logic ex_take;
    logic ld_take;

    assign alloc_ready = (count != rob_cnt_t'(DEPTH)) && !head.flush_all;
    assign alloc_nick  = tail_ptr;
    assign alloc_fire  = alloc_valid && alloc_ready;

    assign dp_store = dp_op inside {OP_SB, OP_SH, OP_SW};

    // completions to a free slot or during a flush are dropped
    assign ex_take = ex_valid && occupied[ex_nick] && !head.flush_all;
    assign ld_take = ld_valid && occupied[ld_nick] && !head.flush_all;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occupied   <= '0;
            dispatched <= '0;
            done       <= '0;
            store      <= '0;
            head_ptr   <= '0;
            tail_ptr   <= '0;
            count      <= '0;
        end else if (head.flush_all) begin
            occupied   <= '0;
            dispatched <= '0;
            done       <= '0;
            store      <= '0;
            head_ptr   <= '0;
            tail_ptr   <= '0;
            count      <= '0;
        end else begin
            if (alloc_fire) begin
                occupied[tail_ptr]   <= 1'b1;
                dispatched[tail_ptr] <= 1'b0;
                done[tail_ptr]       <= 1'b0;
                store[tail_ptr]      <= 1'b0;
                tail_ptr             <= tail_ptr + 1'b1;
            end

            if (dp_valid) begin
                dispatched[dp_nick] <= 1'b1;
                store[dp_nick]      <= dp_store;
            end

            if (ex_take) begin
                done[ex_nick] <= 1'b1;
            end
            if (ld_take) begin
                done[ld_nick] <= 1'b1;
            end

            // pop the head
            if (head.retire) begin
                occupied[head_ptr]   <= 1'b0;
                dispatched[head_ptr] <= 1'b0;
                done[head_ptr]       <= 1'b0;
                store[head_ptr]      <= 1'b0;
                head_ptr             <= head_ptr + 1'b1;
            end

            case ({alloc_fire, head.retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // a fresh entry starts as not taken
        if (alloc_fire) begin
            ac[tail_ptr] <= 1'b0;
        end

        if (dp_valid) begin
            regnm[dp_nick] <= dp_regnm;
            pd[dp_nick]    <= dp_pd;
        end

        if (ex_take) begin
            data[ex_nick] <= ex_data;
            ac[ex_nick]   <= ex_ac;
            jpc[ex_nick]  <= ex_jpc;
        end

        if (ld_take) begin
            data[ld_nick] <= ld_data;
        end
    end

    // head view, valid only once dispatch has filled in the class
    assign head.head_valid   = occupied[head_ptr] && dispatched[head_ptr];
    assign head.head_done    = done[head_ptr];
    assign head.head_store   = store[head_ptr];
    assign head.head_mispred = pd[head_ptr] ^ ac[head_ptr];
    assign head.head_regnm   = regnm[head_ptr];
    assign head.head_data    = data[head_ptr];
    assign head.head_jpc     = jpc[head_ptr];
    assign head.head_nick    = head_ptr;

endmodule

/* hdl/rob_commit_ctrl.sv */
`timescale 1ns/1ps

module rob_commit_ctrl (
    input  logic                  clk,
    input  logic                  arst_n,
    rob_head_if.commit            head,
    output logic                  rf_valid,
    output cpu_types_pkg::regnm_t rf_regnm,
    output cpu_types_pkg::data_t  rf_data,
    output rob_pkg::nick_t        rf_nick,
    output logic                  store_valid,
    output rob_pkg::nick_t        store_nick,
    input  logic                  store_ready,
    output logic                  flush,
    output cpu_types_pkg::addr_t  redirect_pc
);
    import cpu_types_pkg::*;
    import rob_pkg::*;

    commit_state_t state;
    commit_state_t state_nx;
    addr_t         jpc_q;

    logic head_ready;
    logic mispred_retire;

    // stores leave without waiting for a completion
    assign head_ready = (state == COMMIT_RUN) && head.head_valid
                        && (head.head_store || head.head_done);

    assign rf_valid    = head_ready && !head.head_store;
    assign rf_regnm    = head.head_regnm;
    assign rf_data     = head.head_data;
    assign rf_nick     = head.head_nick;

    assign store_valid = head_ready && head.head_store;
    assign store_nick  = head.head_nick;

    assign head.retire = rf_valid || (store_valid && store_ready);

    // the branch still writes its register before the flush
    assign mispred_retire = rf_valid && head.head_mispred;

    always_comb begin
        state_nx = state;
        case (state)
            COMMIT_RUN: begin
                if (mispred_retire) begin
                    state_nx = COMMIT_FLUSH;
                end
            end
            COMMIT_FLUSH: begin
                state_nx = COMMIT_RUN;
            end
            default: begin
                state_nx = COMMIT_RUN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= COMMIT_RUN;
        end else begin
            state <= state_nx;
        end
    end

    // redirect target of the retiring branch
    always_ff @(posedge clk) begin
        if (mispred_retire) begin
            jpc_q <= head.head_jpc;
        end
    end

    assign flush          = (state == COMMIT_FLUSH);
    assign redirect_pc    = jpc_q;
    assign head.flush_all = flush;

endmodule

/* hdl/rob_top.sv */
`timescale 1ns/1ps

module rob_top (
    input  logic                   clk,
    input  logic                   arst_n,

    // allocation at rename
    input  logic                   alloc_valid,
    output logic                   alloc_ready,
    output rob_pkg::nick_t         alloc_nick,

    // dispatch
    input  logic                   dp_valid,
    input  rob_pkg::nick_t         dp_nick,
    input  cpu_types_pkg::opcode_t dp_op,
    input  cpu_types_pkg::regnm_t  dp_regnm,
    input  logic                   dp_pd,

    // execution unit
    input  logic                   ex_valid,
    input  rob_pkg::nick_t         ex_nick,
    input  cpu_types_pkg::data_t   ex_data,
    input  logic                   ex_ac,
    input  cpu_types_pkg::addr_t   ex_jpc,

    // load unit
    input  logic                   ld_valid,
    input  rob_pkg::nick_t         ld_nick,
    input  cpu_types_pkg::data_t   ld_data,

    // register file write
    output logic                   rf_valid,
    output cpu_types_pkg::regnm_t  rf_regnm,
    output cpu_types_pkg::data_t   rf_data,
    output rob_pkg::nick_t         rf_nick,

    // store buffer release
    output logic                   store_valid,
    output rob_pkg::nick_t         store_nick,
    input  logic                   store_ready,

    // fetch redirect
    output logic                   flush,
    output cpu_types_pkg::addr_t   redirect_pc
);

    rob_head_if u_head_if ();

    rob_entry_table u_table (
        .clk         (clk),
        .arst_n      (arst_n),
        .alloc_valid (alloc_valid),
        .alloc_ready (alloc_ready),
        .alloc_nick  (alloc_nick),
        .dp_valid    (dp_valid),
        .dp_nick     (dp_nick),
        .dp_op       (dp_op),
        .dp_regnm    (dp_regnm),
        .dp_pd       (dp_pd),
        .ex_valid    (ex_valid),
        .ex_nick     (ex_nick),
        .ex_data     (ex_data),
        .ex_ac       (ex_ac),
        .ex_jpc      (ex_jpc),
        .ld_valid    (ld_valid),
        .ld_nick     (ld_nick),
        .ld_data     (ld_data),
        .head        (u_head_if.tbl)
    );

    rob_commit_ctrl u_commit (
        .clk         (clk),
        .arst_n      (arst_n),
        .head        (u_head_if.commit),
        .rf_valid    (rf_valid),
        .rf_regnm    (rf_regnm),
        .rf_data     (rf_data),
        .rf_nick     (rf_nick),
        .store_valid (store_valid),
        .store_nick  (store_nick),
        .store_ready (store_ready),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

endmodule

/* sim/rob_checker.sv */
`timescale 1ns/1ps

module rob_checker (
    input logic           clk,
    input logic           arst_n,
    input logic           alloc_valid,
    input logic           alloc_ready,
    input rob_pkg::nick_t alloc_nick,
    input logic           rf_valid,
    input logic           store_valid,
    input logic           flush
);

    int unsigned assert_fails = 0;

    // redirect is a single-cycle pulse
    flush_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !flush)
    else begin
        $error("flush was high in two consecutive cycles");
        assert_fails++;
    end

    one_commit_kind: assert property (@(posedge clk) disable iff (!arst_n)
        !(rf_valid && store_valid))
    else begin
        $error("rf_valid and store_valid were high together");
        assert_fails++;
    end

    // tail must not move on a refused request
    no_alloc_when_busy: assert property (@(posedge clk) disable iff (!arst_n)
        alloc_valid && !alloc_ready && !flush |=> alloc_nick == $past(alloc_nick))
    else begin
        $error("an allocation was taken while alloc_ready was low");
        assert_fails++;
    end

endmodule

bind rob_top rob_checker u_checker (
    .clk         (clk),
    .arst_n      (arst_n),
    .alloc_valid (alloc_valid),
    .alloc_ready (alloc_ready),
    .alloc_nick  (alloc_nick),
    .rf_valid    (rf_valid),
    .store_valid (store_valid),
    .flush       (flush)
);

/* sim/rob_tb.sv */
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_tb;
    import cpu_types_pkg::*;
    import rob_pkg::*;

    localparam int CYCLES_PER_RECORD = 200;

    logic    clk;
    logic    arst_n;
    logic    alloc_valid, alloc_ready;
    nick_t   alloc_nick;
    logic    dp_valid, dp_pd;
    nick_t   dp_nick;
    opcode_t dp_op;
    regnm_t  dp_regnm;
    logic    ex_valid, ex_ac;
    nick_t   ex_nick;
    data_t   ex_data;
    addr_t   ex_jpc;
    logic    ld_valid;
    nick_t   ld_nick;
    data_t   ld_data;
    logic    rf_valid;
    regnm_t  rf_regnm;
    data_t   rf_data;
    nick_t   rf_nick;
    logic    store_valid, store_ready;
    nick_t   store_nick;
    logic    flush;
    addr_t   redirect_pc;

    // stim records, and the nick handed out for each allocation ordinal
    logic [7:0]  rec_kind [256];
    logic [31:0] rec_a [256];
    logic [31:0] rec_b [256];
    logic [31:0] rec_c [256];
    logic [31:0] rec_d [256];
    nick_t       nick_of [256];
    int          rec_cnt = 0;
    int          ord_cnt = 0;
    logic        loaded = 1'b0;

    // nicks still in the buffer, oldest first
    nick_t       live_nick [$];

    // commit events as kind plus two values
    logic [7:0]  exp_kind [$];
    logic [31:0] exp_a [$];
    logic [31:0] exp_b [$];
    logic [7:0]  obs_kind [$];
    logic [31:0] obs_a [$];
    logic [31:0] obs_b [$];
    int          cmp_idx = 0;
    int          drain_no = 0;
    int          errors = 0;
    int          checks = 0;

    rob_top u_dut (.*);

    always #20 clk = ~clk;

    task automatic add_expected(input logic [7:0] kind, input logic [31:0] a, input logic [31:0] b);
        exp_kind.push_back(kind);
        exp_a.push_back(a);
        exp_b.push_back(b);
    endtask

    task automatic add_observed(input logic [7:0] kind, input logic [31:0] a, input logic [31:0] b);
        obs_kind.push_back(kind);
        obs_a.push_back(a);
        obs_b.push_back(b);
    endtask

    task automatic check_nick(input string name, input nick_t exp_nick, input nick_t act_nick);
        checks++;
        if (act_nick !== exp_nick) begin
            errors++;
            $display("ERROR %s: nick expected %0d, actual %0d", name, exp_nick, act_nick);
        end
    endtask

    // retirement must follow allocation order
    task automatic check_retire_nick(input string name, input nick_t act_nick);
        if (live_nick.size() == 0) begin
            errors++;
            $display("%s: nick %0d retired while no allocated entry was outstanding",
                     name, act_nick);
        end else begin
            check_nick(name, live_nick.pop_front(), act_nick);
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && rf_valid) begin
            add_observed("W", 32'(rf_regnm), rf_data);
            check_retire_nick("register write", rf_nick);
        end
        if (arst_n && store_valid && store_ready) begin
            add_observed("S", 32'(store_nick), '0);
            check_retire_nick("store release", store_nick);
        end
        if (arst_n && flush) begin
            add_observed("F", redirect_pc, '0);
            // every younger entry is discarded
            live_nick.delete();
        end
    end

    // store buffer back-pressure
    initial begin
        wait (arst_n);
        forever begin
            @(posedge clk);
            #2;
            store_ready = ($urandom % 4) != 0;
        end
    end

    task automatic check_rf(input string name, input regnm_t exp_regnm, input data_t exp_data,
                            input regnm_t act_regnm, input data_t act_data);
        checks++;
        if (act_regnm !== exp_regnm || act_data !== exp_data) begin
            errors++;
            $display("ERROR %s: register write expected x%0d=%h, actual x%0d=%h",
                     name, exp_regnm, exp_data, act_regnm, act_data);
        end
    endtask

    task automatic check_store(input string name, input nick_t exp_nick, input nick_t act_nick);
        checks++;
        if (act_nick !== exp_nick) begin
            errors++;
            $display("ERROR %s: store nick expected %0d, actual %0d", name, exp_nick, act_nick);
        end
    endtask

    task automatic check_redirect(input string name, input addr_t exp_pc, input addr_t act_pc);
        checks++;
        if (act_pc !== exp_pc) begin
            errors++;
            $display("ERROR %s: redirect pc expected %h, actual %h", name, exp_pc, act_pc);
        end
    endtask

    task automatic check_count(input string name, input rob_cnt_t exp_cnt, input rob_cnt_t act_cnt);
        checks++;
        if (act_cnt !== exp_cnt) begin
            errors++;
            $display("ERROR %s: accepted allocations expected %0d, actual %0d",
                     name, exp_cnt, act_cnt);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic dispatch_entry(input nick_t nick, input opcode_t op, input regnm_t regnm,
                                  input logic pd);
        dp_valid = 1'b1;
        dp_nick  = nick;
        dp_op    = op;
        dp_regnm = regnm;
        dp_pd    = pd;
        wait_cycles(1);
        dp_valid = 1'b0;
    endtask

    task automatic alloc_dispatch(input opcode_t op, input regnm_t regnm, input logic pd);
        nick_t nick;
        alloc_valid = 1'b1;
        @(negedge clk);
        while (!alloc_ready) begin
            @(negedge clk);
        end
        nick = alloc_nick;
        nick_of[ord_cnt] = nick;
        ord_cnt++;
        live_nick.push_back(nick);
        wait_cycles(1);
        alloc_valid = 1'b0;
        dispatch_entry(nick, op, regnm, pd);
    endtask

    task automatic complete_ex(input nick_t nick, input data_t data, input logic ac,
                               input addr_t jpc);
        ex_valid = 1'b1;
        ex_nick  = nick;
        ex_data  = data;
        ex_ac    = ac;
        ex_jpc   = jpc;
        wait_cycles(1);
        ex_valid = 1'b0;
    endtask

    task automatic complete_ld(input nick_t nick, input data_t data);
        ld_valid = 1'b1;
        ld_nick  = nick;
        ld_data  = data;
        wait_cycles(1);
        ld_valid = 1'b0;
    endtask

    task automatic drain_and_compare();
        string name;
        drain_no++;
        name = $sformatf("drain %0d", drain_no);
        while (obs_kind.size() < exp_kind.size()) begin
            wait_cycles(1);
        end
        while (cmp_idx < exp_kind.size()) begin
            if (obs_kind[cmp_idx] != exp_kind[cmp_idx]) begin
                errors++;
                $display("%s: event %0d is a %s event where a %s event was expected",
                         name, cmp_idx, obs_kind[cmp_idx], exp_kind[cmp_idx]);
            end else if (exp_kind[cmp_idx] == "W") begin
                check_rf(name, regnm_t'(exp_a[cmp_idx]), exp_b[cmp_idx],
                         regnm_t'(obs_a[cmp_idx]), obs_b[cmp_idx]);
            end else if (exp_kind[cmp_idx] == "S") begin
                check_store(name, nick_t'(exp_a[cmp_idx]), nick_t'(obs_a[cmp_idx]));
            end else begin
                check_redirect(name, exp_a[cmp_idx], obs_a[cmp_idx]);
            end
            cmp_idx++;
        end
        // tail is back at 0 after a redirect
        if (exp_kind.size() > 0 && exp_kind[exp_kind.size()-1] == "F") begin
            @(negedge clk);
            check_nick(name, '0, alloc_nick);
            wait_cycles(1);
        end
    endtask

    task automatic fill_and_hold(input regnm_t regnm, input data_t data);
        nick_t    first_nick;
        rob_cnt_t taken;
        taken = '0;
        alloc_valid = 1'b1;
        @(negedge clk);
        first_nick = alloc_nick;
        while (alloc_ready && taken <= rob_cnt_t'(`ROB_DEPTH)) begin
            nick_of[ord_cnt] = alloc_nick;
            ord_cnt++;
            live_nick.push_back(alloc_nick);
            taken++;
            @(negedge clk);
        end
        check_count("fill", rob_cnt_t'(`ROB_DEPTH), taken);
        // one more cycle of request against a full buffer
        @(negedge clk);
        if (alloc_ready) begin
            errors++;
            $display("fill: alloc_ready is high although every entry is taken");
        end
        check_nick("fill", first_nick, alloc_nick);
        wait_cycles(1);
        alloc_valid = 1'b0;
        dispatch_entry(first_nick, OP_ALU, regnm, 1'b0);
        complete_ex(first_nick, data, 1'b0, '0);
        while (!alloc_ready) begin
            @(negedge clk);
        end
        check_nick("reuse", first_nick, alloc_nick);
        wait_cycles(1);
    endtask

    initial begin
        int               fd;
        int               code;
        int               seed;
        logic [63:0]      tok;
        logic [8*128-1:0] line;
        logic [31:0]      a, b, c, d;
        seed = $urandom(32'h31fe_6312);
        clk = 1'b0;
        arst_n = 1'b0;
        alloc_valid = 1'b0;
        dp_valid = 1'b0;
        dp_nick = '0;
        dp_op = OP_ALU;
        dp_regnm = '0;
        dp_pd = 1'b0;
        ex_valid = 1'b0;
        ex_nick = '0;
        ex_data = '0;
        ex_ac = 1'b0;
        ex_jpc = '0;
        ld_valid = 1'b0;
        ld_nick = '0;
        ld_data = '0;
        store_ready = 1'b1;

        fd = $fopen("sim/rob_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open sim/rob_stim.txt for reading");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                a = '0;
                b = '0;
                c = '0;
                d = '0;
                case (tok[7:0])
                    "#": code = $fgets(line, fd);
                    "A": code = $fscanf(fd, "%h %h %h", a, b, c);
                    "X": code = $fscanf(fd, "%d %h %h %h", a, b, c, d);
                    "L": code = $fscanf(fd, "%d %h", a, b);
                    "W", "M": code = $fscanf(fd, "%h %h", a, b);
                    "S": code = $fscanf(fd, "%d", a);
                    "F": code = $fscanf(fd, "%h", a);
                    "D": code = 0;
                    default: begin
                        errors++;
                        $display("unknown record kind %s in the stim file", tok[7:0]);
                    end
                endcase
                if (tok[7:0] inside {"A", "X", "L", "W", "S", "F", "D", "M"}) begin
                    rec_kind[rec_cnt] = tok[7:0];
                    rec_a[rec_cnt] = a;
                    rec_b[rec_cnt] = b;
                    rec_c[rec_cnt] = c;
                    rec_d[rec_cnt] = d;
                    rec_cnt++;
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;

        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        wait_cycles(2);

        for (int r = 0; r < rec_cnt; r++) begin
            case (rec_kind[r])
                "A": alloc_dispatch(opcode_t'(rec_a[r][3:0]), regnm_t'(rec_b[r]), rec_c[r][0]);
                "X": complete_ex(nick_of[rec_a[r]], rec_b[r], rec_c[r][0], rec_d[r]);
                "L": complete_ld(nick_of[rec_a[r]], rec_b[r]);
                "W": add_expected("W", rec_a[r], rec_b[r]);
                "S": add_expected("S", 32'(nick_of[rec_a[r]]), '0);
                "F": add_expected("F", rec_a[r], '0);
                "D": drain_and_compare();
                "M": fill_and_hold(regnm_t'(rec_a[r]), rec_b[r]);
                default: ;
            endcase
            wait_cycles($urandom % 3);
        end

        wait_cycles(20);
        if (obs_kind.size() != exp_kind.size()) begin
            errors++;
            $display("%0d commit events were seen but %0d were expected",
                     obs_kind.size(), exp_kind.size());
        end
        errors += u_dut.u_checker.assert_fails;
        $display("errors: %0d  checks: %0d  assertion failures: %0d",
                 errors, checks, u_dut.u_checker.assert_fails);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (rec_cnt * CYCLES_PER_RECORD + 40) @(posedge clk);
        $display("timeout: the stim records did not complete in %0d cycles",
                 rec_cnt * CYCLES_PER_RECORD + 40);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* sim/rob_stim.txt */
# A op(hex) regnm(hex) pd | X ordinal data(hex) ac jpc(hex) | L ordinal data(hex)
# W regnm(hex) data(hex) | S ordinal | F pc(hex) | D drain | M regnm(hex) data(hex)
A 0 01 0
A 0 02 0
A 1 03 0
X 1 00000022 0 00000000
L 2 00000033
X 0 00000011 0 00000000
W 01 00000011
W 02 00000022
W 03 00000033
D
A 4 00 0
A 0 04 0
A 2 00 0
A 0 05 0
X 4 00000044 0 00000000
X 6 00000066 0 00000000
S 3
W 04 00000044
S 5
W 05 00000066
D
A 5 06 1
A 0 07 0
X 8 00000088 0 00000000
X 7 00000077 0 00000400
W 06 00000077
F 00000400
D
A 6 08 1
X 9 00000099 1 00000500
W 08 00000099
D
M 0a 0000beef
W 0a 0000beef
D

/* all.f */
+incdir+hdl
hdl/cpu_types_pkg.sv
hdl/rob_pkg.sv
hdl/rob_head_if.sv
hdl/rob_entry_table.sv
hdl/rob_commit_ctrl.sv
hdl/rob_top.sv
sim/rob_checker.sv
sim/rob_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
